// File: cpuControl.f
+incdir+design
design/ctrlSeqPkg.sv
design/ctrlOpPkg.sv
design/seqIf.sv
design/intArbiter.sv
design/opPredecode.sv
design/tSequencer.sv
design/ctrlDecode.sv
design/cpuControl.sv
tb/clkGen.sv
tb/cpuControlTb.sv

// File: design/cpuControl.sv
// cpuControl
// control sequencer top with interrupt arbiter, opcode predecode,
// T-state sequencer and registered control-word decode
`timescale 1ns/1ps
`include "cpuControl_cfg.svh"

module cpuControl (
    input  logic                 phi1,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 nmi,
    input  logic                 irq,
    input  logic [7:0]           opcodeIn,
    input  logic [7:0]           statusReg,
    output ctrlOpPkg::ctrlWord_t ctrl,
    output logic                 sync,
    output logic                 nmiAck,
    output logic                 irqAck
);
    import ctrlSeqPkg::*;
    import ctrlOpPkg::*;

    intSrc_t    pending;
    logic       take;
    logic       done;
    logic       fetchCycle;
    opcode_t    opcode;
    insnClass_t cls;

    seqIf seq_i ();

    intArbiter arb_i (
        .phi1    (phi1),
        .rst     (rst),
        .nmi     (nmi),
        .irq     (irq),
        .statusI (statusReg[`STATUS_I]),
        .take    (take),
        .done    (done),
        .pending (pending),
        .nmiAck  (nmiAck),
        .irqAck  (irqAck)
    );

    opPredecode pre_i (
        .phi1       (phi1),
        .rst        (rst),
        .opcodeIn   (opcodeIn),
        .fetchCycle (fetchCycle),
        .rdy        (rdy),
        .opcode     (opcode),
        .cls        (cls)
    );

    tSequencer seqr_i (
        .phi1       (phi1),
        .rst        (rst),
        .rdy        (rdy),
        .opcode     (opcode),
        .cls        (cls),
        .statusReg  (statusReg),
        .pending    (pending),
        .take       (take),
        .done       (done),
        .fetchCycle (fetchCycle),
        .seq        (seq_i.seqSrc)
    );

    ctrlDecode dec_i (
        .phi1 (phi1),
        .rst  (rst),
        .seq  (seq_i.seqDst),
        .ctrl (ctrl)
    );

    assign sync = ctrl.fetch;  // sync is the fetch bit of the word

endmodule

// File: design/cpuControl_cfg.svh
// cpuControl configuration
// opcode bytes, instruction lengths in cycles and status bit positions
`ifndef CPU_CONTROL_CFG_SVH
`define CPU_CONTROL_CFG_SVH

`define OP_BRK            8'h00
`define OP_LDA_ZP         8'hA5
`define OP_LDA_IMM        8'hA9
`define OP_BEQ            8'hF0
`define OP_INC_ZP         8'hE6
`define OP_NOP            8'hEA

`define LDA_IMM_CYCLES    3'd2
`define NOP_CYCLES        3'd2
`define LDA_ZP_CYCLES     3'd3
`define INC_ZP_CYCLES     3'd5
`define BEQ_CYCLES        3'd2  // not taken
`define BEQ_TAKEN_CYCLES  3'd3  // no page crossing
`define BRK_CYCLES        3'd7  // also interrupt and reset entry

`define STATUS_Z          1
`define STATUS_I          2

`endif

// File: design/ctrlDecode.sv
// ctrlDecode
// maps the sequencer state to the control word one cycle later and carries
// the lda register load over into the next T2
`timescale 1ns/1ps

module ctrlDecode (
    input  logic                 phi1,
    input  logic                 rst,
    seqIf.seqDst                 seq,
    output ctrlOpPkg::ctrlWord_t ctrl
);
    import ctrlSeqPkg::*;
    import ctrlOpPkg::*;

    ctrlWord_t wordNext;
    logic      loadPend;  // lda finished and owes loadA
    logic      ldaLast;

    // shared by brk, interrupt and reset entry
    function automatic ctrlWord_t brkWord(tState_t t, intSrc_t src);
        ctrlWord_t w;
        w = '0;
        w.memRead = 1'b1;
        case (t)
            T2: w.pcInc = (src == None);  // software brk skips its signature byte
            T3, T4, T5: begin
                w.pushStack = 1'b1;
                if (src != Rst) begin  // reset moves sp but only reads
                    w.memRead  = 1'b0;
                    w.memWrite = 1'b1;
                end
            end
            T6, T7: w.vectorFetch = 1'b1;
            default: ;
        endcase
        return w;
    endfunction

    assign ldaLast = (seq.state == Fetch && seq.tState == T2 && seq.opcode == OpLdaImm) ||
                     (seq.state == ExecNorm && seq.tState == T3 && seq.opcode == OpLdaZp);

    always_comb begin
        wordNext = '0;
        case (seq.state)
            Init, ExecBrk: wordNext = brkWord(seq.tState, seq.intSrc);
            Fetch: begin
                if (seq.tState == T1) begin
                    wordNext.fetch   = 1'b1;
                    wordNext.memRead = 1'b1;
                    wordNext.pcInc   = 1'b1;
                end else if (seq.cls == Brk) begin
                    wordNext = brkWord(seq.tState, seq.intSrc);
                end else begin
                    wordNext.memRead = 1'b1;  // operand byte
                    wordNext.pcInc   = (seq.opcode != OpNop);
                end
            end
            ExecNorm: begin
                wordNext.memRead = 1'b1;
                wordNext.addrZp  = 1'b1;
            end
            ExecRmw: begin
                wordNext.addrZp   = 1'b1;
                wordNext.memRead  = (seq.tState == T3);
                wordNext.memWrite = (seq.tState != T3);  // T4 writes the old value back
                wordNext.aluInc   = (seq.tState == T4);
            end
            ExecBranch: begin
                wordNext.memRead   = 1'b1;  // dummy read
                wordNext.branchAdd = 1'b1;
            end
            default: ;
        endcase
        if (seq.tState == T2)
            wordNext.loadA = loadPend;
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            ctrl     <= '0;
            loadPend <= 1'b0;
        end else if (seq.advance) begin
            ctrl <= wordNext;
            if (ldaLast)
                loadPend <= 1'b1;  // lda imm rearms in its own T2
            else if (seq.tState == T2)
                loadPend <= 1'b0;
        end
    end

endmodule

// File: design/ctrlOpPkg.sv
// ctrlOpPkg
// opcode and execution class encodings plus the per-cycle control word
`include "cpuControl_cfg.svh"

package ctrlOpPkg;

    // supported subset, anything else is folded onto OpNop
    typedef enum logic [7:0] {
        OpBrk    = `OP_BRK,
        OpLdaZp  = `OP_LDA_ZP,
        OpLdaImm = `OP_LDA_IMM,
        OpBeq    = `OP_BEQ,
        OpIncZp  = `OP_INC_ZP,
        OpNop    = `OP_NOP
    } opcode_t;

    typedef enum logic [1:0] {
        Norm,    // lda imm, lda zp, nop
        Rmw,     // inc zp
        Branch,  // beq
        Brk
    } insnClass_t;

    // one bit per datapath action, fetch doubles as sync
    typedef struct packed {
        logic fetch;        // opcode fetch cycle
        logic memRead;
        logic memWrite;
        logic addrZp;       // address from zero page operand
        logic aluInc;
        logic pushStack;    // stack address, sp decrements
        logic vectorFetch;
        logic loadA;        // leftover from lda
        logic branchAdd;    // pc plus offset
        logic pcInc;
    } ctrlWord_t;

endpackage

// File: design/ctrlSeqPkg.sv
// ctrlSeqPkg
// sequencer types: FSM state, cycle index within an instruction, entry cause
package ctrlSeqPkg;

    // Fetch spans T1 and T2 since the class is only known from the bus at T2
    typedef enum logic [2:0] {
        Init,        // reset entry
        Fetch,
        ExecNorm,    // 3-cycle loads
        ExecRmw,
        ExecBranch,  // taken branch only
        ExecBrk      // brk opcode and interrupt entry
    } seqState_t;

    typedef enum logic [2:0] {
        T1 = 3'd1,   // opcode fetch
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6,
        T7 = 3'd7
    } tState_t;

    // priority runs Rst, then Nmi, then Irq
    typedef enum logic [1:0] {
        None,
        Rst,
        Nmi,
        Irq
    } intSrc_t;

endpackage

// File: design/intArbiter.sv
// intArbiter
// latches reset, the nmi edge and the masked irq level, offers the highest
// priority cause and acknowledges it when its entry sequence completes
`timescale 1ns/1ps

module intArbiter (
    input  logic                phi1,
    input  logic                rst,
    input  logic                nmi,
    input  logic                irq,
    input  logic                statusI,
    input  logic                take,
    input  logic                done,
    output ctrlSeqPkg::intSrc_t pending,
    output logic                nmiAck,
    output logic                irqAck
);
    import ctrlSeqPkg::*;

    logic    nmiPrev;   // nmi one cycle back
    logic    nmiLatch;  // edge seen and not yet serviced
    logic    rstPend;
    intSrc_t svc;       // cause accepted by the sequencer
    logic    nmiEdge;
    logic    irqLive;

    assign nmiEdge = nmi & ~nmiPrev;
    assign irqLive = irq & ~statusI;  // level sensitive, I masks it

    always_comb begin
        if (rstPend)
            pending = Rst;
        else if (svc != None)
            pending = svc;  // held steady for the whole entry
        else if (nmiLatch)
            pending = Nmi;
        else if (irqLive)
            pending = Irq;
        else
            pending = None;
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            nmiPrev  <= nmi;  // a level already high is no edge
            nmiLatch <= 1'b0;
            rstPend  <= 1'b1;
            svc      <= None;
            nmiAck   <= 1'b0;
            irqAck   <= 1'b0;
        end else begin
            nmiPrev <= nmi;
            nmiAck  <= done && (svc == Nmi);  // lines up with the T7 word
            irqAck  <= done && (svc == Irq);
            if (done && svc == Nmi)
                nmiLatch <= nmiEdge;  // a new edge in the done cycle survives
            else if (nmiEdge)
                nmiLatch <= 1'b1;
            if (done)
                rstPend <= 1'b0;
            if (take)
                svc <= pending;
            else if (done)
                svc <= None;
        end
    end

endmodule

// File: design/opPredecode.sv
// opPredecode
// captures the opcode byte in the fetch cycle and sorts it into a class
`timescale 1ns/1ps

module opPredecode (
    input  logic                  phi1,
    input  logic                  rst,
    input  logic [7:0]            opcodeIn,
    input  logic                  fetchCycle,
    input  logic                  rdy,
    output ctrlOpPkg::opcode_t    opcode,
    output ctrlOpPkg::insnClass_t cls
);
    import ctrlOpPkg::*;

    opcode_t busOp;  // bus byte mapped onto the supported set
    opcode_t opReg;  // held for the rest of the instruction

    always_comb begin
        case (opcodeIn)
            OpBrk, OpLdaZp, OpLdaImm, OpBeq, OpIncZp, OpNop:
                busOp = opcode_t'(opcodeIn);
            default:
                busOp = OpNop;  // unsupported bytes run as nop
        endcase
    end

    // sampled at the edge that ends the sync cycle
    always_ff @(posedge phi1) begin
        if (rst)
            opReg <= OpNop;
        else if (fetchCycle && rdy)
            opReg <= busOp;
    end

    // the sequencer decides at T2 so it sees the bus byte directly then
    assign opcode = fetchCycle ? busOp : opReg;

    always_comb begin
        case (opcode)
            OpIncZp: cls = Rmw;
            OpBeq:   cls = Branch;
            OpBrk:   cls = Brk;
            default: cls = Norm;
        endcase
    end

endmodule

// File: design/seqIf.sv
// seqIf
// sequencer state bundle handed from tSequencer to ctrlDecode
`timescale 1ns/1ps

interface seqIf;
    import ctrlSeqPkg::*;
    import ctrlOpPkg::*;

    seqState_t  state;
    tState_t    tState;
    opcode_t    opcode;   // bus look-through during the fetch cycle
    insnClass_t cls;
    intSrc_t    intSrc;   // cause of the running entry
    logic       advance;  // step enable, follows rdy

    modport seqSrc (output state, tState, opcode, cls, intSrc, advance);
    modport seqDst (input state, tState, opcode, cls, intSrc, advance);

endinterface

// File: design/tSequencer.sv
// tSequencer
// class FSM and T-state counter, ends each instruction at its length, takes
// branches on Z and swaps in the brk sequence for pending interrupts
`timescale 1ns/1ps
`include "cpuControl_cfg.svh"

module tSequencer (
    input  logic                  phi1,
    input  logic                  rst,
    input  logic                  rdy,
    input  ctrlOpPkg::opcode_t    opcode,
    input  ctrlOpPkg::insnClass_t cls,
    input  logic [7:0]            statusReg,
    input  ctrlSeqPkg::intSrc_t   pending,
    output logic                  take,
    output logic                  done,
    output logic                  fetchCycle,
    seqIf.seqSrc                  seq
);
    import ctrlSeqPkg::*;
    import ctrlOpPkg::*;

    seqState_t  state;
    seqState_t  stateNext;
    tState_t    tState;
    tState_t    tNext;
    intSrc_t    activeSrc;  // None for a software brk
    logic [2:0] normLen;
    logic [2:0] insnLen;    // cycles of the running sequence
    logic       branchTaken;
    logic       lastCycle;
    logic       insnEnd;    // last cycle of a real instruction
    logic       entryEnd;   // last cycle of reset, brk or interrupt entry
    logic       entryReq;

    assign branchTaken = statusReg[`STATUS_Z];  // beq only

    always_comb begin
        case (opcode)
            OpLdaZp:  normLen = `LDA_ZP_CYCLES;
            OpLdaImm: normLen = `LDA_IMM_CYCLES;
            default:  normLen = `NOP_CYCLES;
        endcase
    end

    always_comb begin
        case (state)
            Init, ExecBrk: insnLen = `BRK_CYCLES;
            ExecNorm:      insnLen = normLen;
            ExecRmw:       insnLen = `INC_ZP_CYCLES;
            ExecBranch:    insnLen = `BEQ_TAKEN_CYCLES;
            default: begin  // Fetch uses the class seen at T2
                case (cls)
                    Rmw:     insnLen = `INC_ZP_CYCLES;
                    Branch:  insnLen = branchTaken ? `BEQ_TAKEN_CYCLES : `BEQ_CYCLES;
                    Brk:     insnLen = `BRK_CYCLES;
                    default: insnLen = normLen;
                endcase
            end
        endcase
    end

    // T1 never matches since every sequence is at least two cycles
    assign lastCycle  = (tState == insnLen);
    assign insnEnd    = lastCycle && (state inside {Fetch, ExecNorm, ExecRmw, ExecBranch});
    assign entryEnd   = lastCycle && (state inside {Init, ExecBrk});
    assign entryReq   = insnEnd && (pending != None);
    assign take       = rdy && entryReq;
    assign done       = rdy && entryEnd && (activeSrc != None);
    assign fetchCycle = (state == Fetch) && (tState == T2);  // sync is out now

    always_comb begin
        stateNext = state;
        tNext     = tState_t'(tState + 3'd1);
        if (insnEnd || entryEnd) begin
            tNext     = T1;
            stateNext = entryReq ? ExecBrk : Fetch;  // entries always fetch after
        end else if (fetchCycle) begin
            case (cls)
                Rmw:     stateNext = ExecRmw;
                Branch:  stateNext = ExecBranch;
                Brk:     stateNext = ExecBrk;
                default: stateNext = ExecNorm;
            endcase
        end
    end

    always_ff @(posedge phi1) begin
        if (rst) begin
            state     <= Init;
            tState    <= T2;  // the cleared word stands in for T1
            activeSrc <= Rst;
        end else if (rdy) begin
            state  <= stateNext;
            tState <= tNext;
            if (take)
                activeSrc <= pending;
            else if (entryEnd)
                activeSrc <= None;
        end
    end

    assign seq.state   = state;
    assign seq.tState  = tState;
    assign seq.opcode  = opcode;
    assign seq.cls     = cls;
    assign seq.intSrc  = activeSrc;
    assign seq.advance = rdy;

endmodule

// File: tb/clkGen.sv
// clkGen
// testbench clock and synchronous reset, reset released on a falling edge
`timescale 1ns/1ps

module clkGen #(
    parameter real period      = 4.0,
    parameter int  resetCycles = 10
) (
    output logic phi1,
    output logic rst
);

    initial begin
        phi1 = 1'b0;
        forever #(period / 2.0) phi1 = ~phi1;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(negedge phi1);  // one rising edge per falling edge
        rst = 1'b0;
    end

endmodule

// File: tb/cpuControlTb.sv
// cpuControlTb
// table-driven testbench for the control sequencer, measures lengths,
// writes and acknowledges per instruction with random rdy stalls
`timescale 1ns/1ps
`include "cpuControl_cfg.svh"

module cpuControlTb;
    import ctrlSeqPkg::*;
    import ctrlOpPkg::*;

    localparam int resetCycles = 10;

    typedef struct {
        logic [7:0] op;
        bit         zBit;
        bit         iBit;
        bit         nmiEvent;   // one-cycle nmi pulse at the sync
        bit         irqLevel;   // held until an acknowledge
        int         stalls;     // rdy low cycles to insert
        int         cycles;     // rdy high cycles sync to sync
        int         writes;
        intSrc_t    ack;
    } row_t;

    logic       phi1;
    logic       rst;
    logic       rdy;
    logic       nmi;
    logic       irq;
    logic [7:0] opcodeIn;
    logic [7:0] statusReg;
    ctrlWord_t  ctrl;
    logic       sync;
    logic       nmiAck;
    logic       irqAck;

    row_t        rows[$];
    logic [31:0] lfsr;
    int          cycleCount = 0;
    int          cycleLimit = 100000;  // replaced once the table is known

    clkGen #(.period(4.0), .resetCycles(resetCycles)) clk_i (.phi1(phi1), .rst(rst));

    cpuControl dut_i (
        .phi1      (phi1),
        .rst       (rst),
        .rdy       (rdy),
        .nmi       (nmi),
        .irq       (irq),
        .opcodeIn  (opcodeIn),
        .statusReg (statusReg),
        .ctrl      (ctrl),
        .sync      (sync),
        .nmiAck    (nmiAck),
        .irqAck    (irqAck)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic bit takeBit();
        bit b;
        b = lfsr[0];
        lfsr = lfsrNext(lfsr);
        return b;
    endfunction

    function automatic bit isLda(input logic [7:0] op);
        return (op == `OP_LDA_IMM) || (op == `OP_LDA_ZP);
    endfunction

    task automatic failNow(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic checkWord(input ctrlWord_t got, input ctrlWord_t exp, input string what);
        if (got !== exp)
            failNow($sformatf("%s: word %b, expected %b", what, got, exp));
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp)
            failNow($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    task automatic checkAck(input intSrc_t got, input intSrc_t exp, input string what);
        if (got != exp)
            failNow($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
    endtask

    task automatic addRow(input logic [7:0] op, input bit z, input bit i, input bit nmiEv,
                          input bit irqLv, input int stalls, input int cycles,
                          input int writes, input intSrc_t ack);
        row_t r;
        r = '{op, z, i, nmiEv, irqLv, stalls, cycles, writes, ack};
        rows.push_back(r);
    endtask

    task automatic buildTable();
        //     op           Z  I  nmi irq stl cyc wr ack
        addRow(`OP_LDA_IMM, 0, 0, 0,  0,  0,  2,  0, None);
        addRow(`OP_NOP,     0, 0, 0,  0,  0,  2,  0, None);
        addRow(`OP_LDA_ZP,  0, 0, 0,  0,  0,  3,  0, None);
        addRow(`OP_INC_ZP,  0, 0, 0,  0,  0,  5,  2, None);
        addRow(`OP_BEQ,     1, 0, 0,  0,  0,  3,  0, None);  // taken
        addRow(`OP_BEQ,     0, 0, 0,  0,  0,  2,  0, None);
        addRow(`OP_BRK,     0, 0, 0,  0,  0,  7,  3, None);
        addRow(8'hFF,       0, 0, 0,  0,  0,  2,  0, None);  // unknown byte
        addRow(`OP_INC_ZP,  0, 0, 1,  0,  0,  12, 5, Nmi);   // inc then entry
        addRow(`OP_INC_ZP,  0, 0, 0,  1,  0,  12, 5, Irq);
        addRow(`OP_INC_ZP,  0, 1, 0,  1,  0,  5,  2, None);  // irq masked
        addRow(`OP_INC_ZP,  0, 0, 1,  1,  0,  12, 5, Nmi);   // nmi wins
        addRow(`OP_LDA_IMM, 0, 0, 0,  0,  3,  2,  0, None);
        addRow(`OP_INC_ZP,  0, 0, 0,  0,  4,  5,  2, None);
        addRow(`OP_BRK,     0, 0, 0,  0,  5,  7,  3, None);
        addRow(`OP_BEQ,     1, 0, 0,  0,  2,  3,  0, None);
        addRow(`OP_LDA_ZP,  0, 0, 0,  0,  3,  3,  0, None);
        addRow(`OP_NOP,     0, 0, 0,  0,  1,  2,  0, None);
    endtask

    task automatic checkReset();
        int idx;
        repeat (resetCycles) begin
            @(negedge phi1);
            checkWord(ctrl, '0, "word during reset");
            checkCount(int'(nmiAck) + int'(irqAck), 0, "acks during reset");
        end
        // the last reset cycle stands in for entry cycle 1
        for (idx = 2; idx <= 7; idx++) begin
            @(negedge phi1);
            checkCount(int'(sync), 0, $sformatf("sync in reset entry cycle %0d", idx));
            checkCount(int'(ctrl.memWrite), 0, $sformatf("write in reset entry cycle %0d", idx));
            checkCount(int'(ctrl.vectorFetch), int'(idx >= 6),
                       $sformatf("vectorFetch in reset entry cycle %0d", idx));
            checkCount(int'(nmiAck) + int'(irqAck), 0,
                       $sformatf("acks in reset entry cycle %0d", idx));
        end
        @(negedge phi1);
        checkCount(int'(sync), 1, "first sync after reset");
    endtask

    task automatic runRow(input row_t r, input bit loadExp, input int n);
        ctrlWord_t prevWord;
        logic      prevSync;
        int        steps;
        int        writes;
        int        pushWrites;
        int        branchAdds;
        int        nmiAcks;
        int        irqAcks;
        int        stallsLeft;
        bit        stepped;
        bit        finished;
        intSrc_t   ackSeen;
        steps = 0;
        writes = 0;
        pushWrites = 0;
        branchAdds = 0;
        nmiAcks = 0;
        irqAcks = 0;
        stallsLeft = r.stalls;
        finished = 1'b0;
        opcodeIn = r.op;  // we sit in the sync cycle here
        statusReg = '0;
        statusReg[`STATUS_Z] = r.zBit;
        statusReg[`STATUS_I] = r.iBit;
        nmi = r.nmiEvent;
        irq = r.irqLevel;
        prevWord = ctrl;
        prevSync = sync;
        while (!finished) begin
            // remaining stalls are forced in before the step that ends the row
            if (stallsLeft > 0 && (steps >= r.cycles - 1 || takeBit())) begin
                rdy = 1'b0;
                stallsLeft--;
            end else begin
                rdy = 1'b1;
            end
            stepped = rdy;
            @(negedge phi1);
            nmi = 1'b0;
            nmiAcks += nmiAck;
            irqAcks += irqAck;
            if (nmiAck || irqAck)
                irq = 1'b0;  // serviced, stop requesting
            if (!stepped) begin
                checkWord(ctrl, prevWord, $sformatf("row %0d word during stall", n));
                checkCount(int'(sync), int'(prevSync), $sformatf("row %0d sync during stall", n));
            end else begin
                steps++;
                if (sync) begin
                    checkCount(int'(ctrl.fetch), 1,
                               $sformatf("row %0d fetch bit with sync", n));
                    finished = 1'b1;
                end else begin
                    checkCount(int'(ctrl.fetch), 0,
                               $sformatf("row %0d fetch bit between syncs", n));
                    writes += ctrl.memWrite;
                    pushWrites += ctrl.memWrite & ctrl.pushStack;
                    branchAdds += ctrl.branchAdd;
                    if (steps == 1)
                        checkCount(int'(ctrl.loadA), int'(loadExp),
                                   $sformatf("row %0d loadA", n));
                end
            end
            prevWord = ctrl;
            prevSync = sync;
        end
        checkCount(steps, r.cycles, $sformatf("row %0d rdy-high cycles", n));
        checkCount(writes, r.writes, $sformatf("row %0d writes", n));
        checkCount(pushWrites, (r.op == `OP_BRK ? 3 : 0) + (r.ack != None ? 3 : 0),
                   $sformatf("row %0d stack pushes", n));
        checkCount(branchAdds, int'(r.op == `OP_BEQ && r.zBit),
                   $sformatf("row %0d branchAdd", n));
        checkCount(nmiAcks + irqAcks, int'(r.ack != None), $sformatf("row %0d ack pulses", n));
        ackSeen = (nmiAcks != 0) ? Nmi : ((irqAcks != 0) ? Irq : None);
        checkAck(ackSeen, r.ack, $sformatf("row %0d acknowledge", n));
    endtask

    // run limit
    always @(posedge phi1) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int idx;
        int total;
        rdy = 1'b1;
        nmi = 1'b0;
        irq = 1'b0;
        opcodeIn = `OP_NOP;
        statusReg = '0;
        lfsr = 32'had43_67ef;
        buildTable();
        total = resetCycles + 8;
        foreach (rows[k])
            total += rows[k].cycles + rows[k].stalls;
        cycleLimit = total + 20;
        checkReset();
        for (idx = 0; idx < rows.size(); idx++)
            runRow(rows[idx], (idx > 0) && isLda(rows[idx - 1].op), idx);
        $display("All tests passed");
        $finish;
    end

endmodule
